// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := fcmp_tb
FILELIST  := filelist.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/fcmp_tb_vectors.svh ====
`ifndef FCMP_TB_VECTORS_SVH
`define FCMP_TB_VECTORS_SVH

// columns: opa, opb, opcode, unordered bit,
// expected {cmp_flag, inv, inf, addsub_agtb, addsub_aeqb}

localparam int NUM_VECS = 30;

localparam vec_t VECTORS [NUM_VECS] = '{
  // signed zeros
  '{32'h00000000, 32'h80000000, `FCMP_OPC_EQ, 1'b0, 5'b10001},
  '{32'h80000000, 32'h00000000, `FCMP_OPC_LT, 1'b0, 5'b00001},
  '{32'h80000000, 32'h00000000, `FCMP_OPC_LE, 1'b0, 5'b10001},
  // unequal exponents, both signs
  '{32'h3F800000, 32'h40000000, `FCMP_OPC_LT, 1'b0, 5'b10000},
  '{32'h3F800000, 32'h40000000, `FCMP_OPC_GT, 1'b0, 5'b00000},
  '{32'h40000000, 32'h3F800000, `FCMP_OPC_GE, 1'b0, 5'b10010},
  '{32'hBF800000, 32'hC0000000, `FCMP_OPC_GT, 1'b0, 5'b10000},
  '{32'hBF800000, 32'hC0000000, `FCMP_OPC_LE, 1'b0, 5'b00000},
  // equal exponents, fraction decides
  '{32'h3FC00000, 32'h3F800000, `FCMP_OPC_NE, 1'b0, 5'b10010},
  '{32'h3FC00000, 32'h3FC00000, `FCMP_OPC_EQ, 1'b0, 5'b10001},
  // sign decides, same magnitude
  '{32'h3F800000, 32'hBF800000, `FCMP_OPC_GT, 1'b0, 5'b10001},
  '{32'hBF800000, 32'h3F800000, `FCMP_OPC_GE, 1'b0, 5'b00001},
  // infinities
  '{32'h7F800000, 32'h7F800000, `FCMP_OPC_EQ, 1'b0, 5'b10101},
  '{32'hFF800000, 32'h7F800000, `FCMP_OPC_LT, 1'b0, 5'b10101},
  '{32'h7F800000, 32'h40000000, `FCMP_OPC_GT, 1'b0, 5'b10110},
  '{32'hBF800000, 32'hFF800000, `FCMP_OPC_GT, 1'b0, 5'b10100},
  // denormals
  '{32'h00000001, 32'h007FFFFF, `FCMP_OPC_LT, 1'b0, 5'b10000},
  '{32'h007FFFFF, 32'h00800000, `FCMP_OPC_LT, 1'b0, 5'b10000},
  '{32'h80000001, 32'h00000000, `FCMP_OPC_LT, 1'b0, 5'b10010},
  '{32'h00000001, 32'h80000001, `FCMP_OPC_NE, 1'b0, 5'b10001},
  // quiet and signalling nan
  '{32'h7FC00000, 32'h3F800000, `FCMP_OPC_EQ, 1'b0, 5'b00010},
  '{32'h7FC00000, 32'h3F800000, `FCMP_OPC_LT, 1'b0, 5'b01010},
  '{32'h7FC00000, 32'h3F800000, `FCMP_OPC_LT, 1'b1, 5'b10010},
  '{32'h3F800000, 32'h7F800001, `FCMP_OPC_EQ, 1'b0, 5'b01000},
  '{32'h3F800000, 32'h7F800001, `FCMP_OPC_NE, 1'b1, 5'b11000},
  '{32'h7F800001, 32'h7F800000, `FCMP_OPC_GE, 1'b1, 5'b10110},
  '{32'h7FC00000, 32'h7FC00000, `FCMP_OPC_NE, 1'b0, 5'b00001},
  '{32'h40000000, 32'h7FC00000, `FCMP_OPC_GE, 1'b0, 5'b01000},
  // unordered bit without nan changes nothing
  '{32'h3F800000, 32'h40000000, `FCMP_OPC_LE, 1'b1, 5'b10000},
  '{32'h40000000, 32'h40000000, `FCMP_OPC_NE, 1'b1, 5'b00001}
};

`endif

// ==== dv/fcmp_tb.sv ====
`include "fcmp_params.svh"

module fcmp_tb;

  import fcmp_fp_pkg::*;
  import fcmp_apb_pkg::*;

  localparam int          CLK_HALF      = 20;
  localparam int          RESET_CYCLES  = 16;
  localparam int          IRQ_TIMEOUT   = 50;
  localparam int          READY_TIMEOUT = 8;
  localparam int          RAND_ITERS    = 60;
  localparam logic [31:0] RAND_SEED     = 32'h0857a3c8;

  // one table row
  typedef struct packed {
    logic [31:0]            opa;
    logic [31:0]            opb;
    logic [`FCMP_OPC_W-1:0] opc;
    logic                   uno;
    logic [4:0]             res;
  } vec_t;

  `include "fcmp_tb_vectors.svh"

  logic     clk;
  logic     rst_n;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;
  logic     irq;

  // expected events since the last clear
  logic [`FCMP_CNT_W-1:0] exp_cmp;
  logic [`FCMP_CNT_W-1:0] exp_inv;

  fcmp_top fcmp_top_i (
    .clk       (clk),
    .rst_n_i   (rst_n),
    .apb_req_i (apb_req),
    .apb_rsp_o (apb_rsp),
    .irq_o     (irq)
  );

  always #CLK_HALF clk = ~clk;

  ////////////////////
  // compare tasks
  ////////////////////

  task automatic check_status(input string name, input fcmp_status_t exp,
                              input fcmp_status_t act);
    if (act !== exp) begin
      $display("ERROR t=%0t %s: expected %h, actual %h", $time, name, exp, act);
      $display("SIMULATION FAILED");
      $fatal(1, "status mismatch");
    end
  endtask

  task automatic check_count(input string name, input fcmp_count_t exp,
                             input fcmp_count_t act);
    if (act !== exp) begin
      $display("ERROR t=%0t %s: expected %h, actual %h", $time, name, exp, act);
      $display("SIMULATION FAILED");
      $fatal(1, "count mismatch");
    end
  endtask

  task automatic check_slverr(input string name, input bit exp, input bit act);
    if (act !== exp) begin
      $display("ERROR t=%0t %s: expected %0b, actual %0b", $time, name, exp, act);
      $display("SIMULATION FAILED");
      $fatal(1, "pslverr mismatch");
    end
  endtask

  ////////////////////
  // apb driver
  ////////////////////

  // samples just after the falling edge of the access cycle
  task automatic wait_ready();
    int n;
    n = 0;
    #1;
    while (!apb_rsp.pready) begin
      if (n >= READY_TIMEOUT) begin
        $display("pready never came back high during an APB access");
        $display("SIMULATION FAILED");
        $fatal(1, "apb timeout");
      end
      n++;
      @(negedge clk);
      #1;
    end
  endtask

  // called on a falling edge and returns on one with the bus idle
  task automatic apb_write(input logic [`FCMP_ADDR_W-1:0] addr,
                           input logic [31:0] data, output bit err);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b1;
    apb_req.paddr   = addr;
    apb_req.pwdata  = data;
    @(negedge clk);
    apb_req.penable = 1'b1;
    wait_ready();
    err = apb_rsp.pslverr;
    @(negedge clk);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic apb_read(input logic [`FCMP_ADDR_W-1:0] addr,
                          output logic [31:0] data, output bit err);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
    apb_req.paddr   = addr;
    @(negedge clk);
    apb_req.penable = 1'b1;
    wait_ready();
    data = apb_rsp.prdata;
    err  = apb_rsp.pslverr;
    @(negedge clk);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  ////////////////////
  // compare sequence
  ////////////////////

  task automatic start_compare(input logic [31:0] a, input logic [31:0] b,
                               input logic [`FCMP_OPC_W-1:0] opc, input logic uno);
    bit err;
    apb_write(`FCMP_REG_OPA, a, err);
    check_slverr("pslverr OPA write", 1'b0, err);
    apb_write(`FCMP_REG_OPB, b, err);
    check_slverr("pslverr OPB write", 1'b0, err);
    apb_write(`FCMP_REG_CTRL, {28'd0, uno, opc}, err);
    check_slverr("pslverr CTRL write", 1'b0, err);
  endtask

  task automatic wait_irq();
    int n;
    n = 0;
    while (!irq) begin
      if (n >= IRQ_TIMEOUT) begin
        $display("irq_o did not rise after the CTRL write");
        $display("SIMULATION FAILED");
        $fatal(1, "irq timeout");
      end
      n++;
      @(negedge clk);
    end
  endtask

  // wait for done and read status twice while tracking the counters
  task automatic finish_compare(input fcmp_result_t res);
    fcmp_status_t exp_st;
    logic [31:0]  rd;
    bit           err;
    wait_irq();
    exp_st.busy   = 1'b0;
    exp_st.done   = 1'b1;
    exp_st.result = res;
    apb_read(`FCMP_REG_STATUS, rd, err);
    check_slverr("pslverr STATUS read", 1'b0, err);
    check_status("STATUS", exp_st, rd[$bits(fcmp_status_t)-1:0]);
    if (irq !== 1'b0) begin
      $display("irq_o stayed high after the STATUS read");
      $display("SIMULATION FAILED");
      $fatal(1, "irq not cleared");
    end
    // second read sees done acked but the result held
    exp_st.done = 1'b0;
    apb_read(`FCMP_REG_STATUS, rd, err);
    check_status("STATUS after ack", exp_st, rd[$bits(fcmp_status_t)-1:0]);
    exp_cmp = exp_cmp + 1'b1;
    if (res.inv) begin
      exp_inv = exp_inv + 1'b1;
    end
  endtask

  task automatic read_count_check(input string name);
    fcmp_count_t exp_cnt;
    logic [31:0] rd;
    bit          err;
    exp_cnt.cmp_count = exp_cmp;
    exp_cnt.inv_count = exp_inv;
    apb_read(`FCMP_REG_COUNT, rd, err);
    check_slverr("pslverr COUNT read", 1'b0, err);
    check_count(name, exp_cnt, rd);
  endtask

  ////////////////////
  // reference model
  ////////////////////

  // normal binary32 to double with the bias moved from 127 to 1023
  function automatic real fp_to_real(input logic [31:0] w);
    logic [63:0] d;
    d = {w[31], {3'b000, w[30:23]} + 11'd896, w[22:0], 29'd0};
    return $bitstoreal(d);
  endfunction

  function automatic logic expected_flag(input logic [`FCMP_OPC_W-1:0] opc,
                                         input real x, input real y);
    logic f;
    case (opc)
      `FCMP_OPC_EQ: f = (x == y);
      `FCMP_OPC_NE: f = (x != y);
      `FCMP_OPC_GT: f = (x > y);
      `FCMP_OPC_GE: f = (x >= y);
      `FCMP_OPC_LT: f = (x < y);
      `FCMP_OPC_LE: f = (x <= y);
      default:      f = 1'b0;
    endcase
    return f;
  endfunction

  // exponent 1..254 only so never nan, inf, zero or denormal
  function automatic logic [31:0] rand_normal();
    logic [31:0] r_sign;
    logic [31:0] r_exp;
    logic [31:0] r_mant;
    r_sign = $urandom_range(1, 0);
    r_exp  = $urandom_range(254, 1);
    r_mant = $urandom;
    return {r_sign[0], r_exp[7:0], r_mant[22:0]};
  endfunction

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    vec_t         v;
    fcmp_result_t res;
    fcmp_status_t zero_st;
    fcmp_status_t busy_st;
    logic [31:0]  a;
    logic [31:0]  b;
    logic [31:0]  r;
    logic [31:0]  rd;
    bit           err;
    clk     = 1'b0;
    rst_n   = 1'b0;
    apb_req = '0;
    exp_cmp = '0;
    exp_inv = '0;
    zero_st = '0;
    void'($urandom(RAND_SEED));
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // idle after reset
    apb_read(`FCMP_REG_STATUS, rd, err);
    check_status("STATUS after reset", zero_st, rd[$bits(fcmp_status_t)-1:0]);
    read_count_check("COUNT after reset");

    // directed table
    for (int i = 0; i < NUM_VECS; i++) begin
      v = VECTORS[i];
      res = v.res;
      start_compare(v.opa, v.opb, v.opc, v.uno);
      finish_compare(res);
    end
    read_count_check("COUNT after table");

    // random normals with some equal or negated pairs
    for (int i = 0; i < RAND_ITERS; i++) begin
      a = rand_normal();
      r = $urandom_range(3, 0);
      case (r[1:0])
        2'd0:    b = a;
        2'd1:    b = {~a[31], a[30:0]};
        default: b = rand_normal();
      endcase
      v.opa = a;
      v.opb = b;
      r = $urandom_range(5, 0);
      v.opc = r[`FCMP_OPC_W-1:0];
      r = $urandom_range(1, 0);
      v.uno = r[0];
      res.cmp_flag    = expected_flag(v.opc, fp_to_real(a), fp_to_real(b));
      res.inv         = 1'b0;
      res.inf         = 1'b0;
      res.addsub_agtb = a[30:0] > b[30:0];
      res.addsub_aeqb = a[30:0] == b[30:0];
      start_compare(v.opa, v.opb, v.opc, v.uno);
      finish_compare(res);
    end
    read_count_check("COUNT after random");

    // second CTRL write lands while busy
    start_compare(32'h3F800000, 32'h40000000, `FCMP_OPC_LT, 1'b0);
    apb_write(`FCMP_REG_CTRL, {28'd0, 1'b0, `FCMP_OPC_GT}, err);
    check_slverr("pslverr CTRL write while busy", 1'b1, err);
    res = 5'b10000;
    finish_compare(res);
    read_count_check("COUNT after busy rejection");

    // unmapped address
    apb_read(5'h14, rd, err);
    check_slverr("pslverr unmapped read", 1'b1, err);

    // counter clear and then one invalid compare
    apb_write(`FCMP_REG_COUNT, 32'hFFFF_FFFF, err);
    check_slverr("pslverr COUNT write", 1'b0, err);
    exp_cmp = '0;
    exp_inv = '0;
    read_count_check("COUNT after clear");
    start_compare(32'h7FC00000, 32'h3F800000, `FCMP_OPC_LT, 1'b0);
    // read lands on the capture cycle
    // busy still high and the 1.0 lt 2.0 result still held
    busy_st.busy   = 1'b1;
    busy_st.done   = 1'b0;
    busy_st.result = 5'b10000;
    apb_read(`FCMP_REG_STATUS, rd, err);
    check_slverr("pslverr STATUS read while busy", 1'b0, err);
    check_status("STATUS while busy", busy_st, rd[$bits(fcmp_status_t)-1:0]);
    // done set by capture survives that read
    res = 5'b01010;
    finish_compare(res);
    read_count_check("COUNT after invalid compare");

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+verilog
+incdir+dv
verilog/fcmp_fp_pkg.sv
verilog/fcmp_apb_pkg.sv
verilog/fcmp_unpack.sv
verilog/pfpu32_fcmp.sv
verilog/fcmp_ctrl_fsm.sv
verilog/fcmp_event_counter.sv
verilog/fcmp_apb_regs.sv
verilog/fcmp_top.sv
dv/fcmp_tb.sv

// ==== verilog/fcmp_apb_pkg.sv ====
`include "fcmp_params.svh"

package fcmp_apb_pkg;

  // apb request from the master
  typedef struct packed {
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [`FCMP_ADDR_W-1:0] paddr;
    logic [31:0]             pwdata;
  } apb_req_t;

  // apb response back to the master
  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // CTRL word, opcode in [2:0], unordered in bit 3
  typedef struct packed {
    logic                   unordered;
    logic [`FCMP_OPC_W-1:0] opcode;
  } fcmp_ctrl_t;

  // STATUS word, result in [4:0]
  typedef struct packed {
    logic                       busy;
    logic                       done;
    fcmp_fp_pkg::fcmp_result_t  result;
  } fcmp_status_t;

  // COUNT word, completed count in the upper half
  typedef struct packed {
    logic [`FCMP_CNT_W-1:0] cmp_count;
    logic [`FCMP_CNT_W-1:0] inv_count;
  } fcmp_count_t;

endpackage

// ==== verilog/fcmp_apb_regs.sv ====
`include "fcmp_params.svh"

module fcmp_apb_regs (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  fcmp_apb_pkg::apb_req_t     apb_req_i,
  output fcmp_apb_pkg::apb_rsp_t     apb_rsp_o,
  input  logic                       busy_i,
  input  logic                       done_i,
  input  logic                       capture_i,
  input  fcmp_fp_pkg::fcmp_result_t  result_i,
  input  fcmp_apb_pkg::fcmp_count_t  count_i,
  output logic                       start_o,
  output logic                       done_clr_o,
  output logic                       count_clr_o,
  output fcmp_fp_pkg::fp32_u         opa_o,
  output fcmp_fp_pkg::fp32_u         opb_o,
  output fcmp_apb_pkg::fcmp_ctrl_t   ctrl_o
);

  import fcmp_fp_pkg::*;
  import fcmp_apb_pkg::*;

  ////////////////////
  // access decode
  ////////////////////

  logic access;
  logic wr;
  logic rd;
  logic sel_opa;
  logic sel_opb;
  logic sel_ctrl;
  logic sel_status;
  logic sel_count;
  logic addr_hit;
  logic busy_err;

  // zero wait states, everything happens in the access phase
  assign access = apb_req_i.psel & apb_req_i.penable;
  assign wr     = access & apb_req_i.pwrite;
  assign rd     = access & ~apb_req_i.pwrite;

  assign sel_opa    = apb_req_i.paddr == `FCMP_REG_OPA;
  assign sel_opb    = apb_req_i.paddr == `FCMP_REG_OPB;
  assign sel_ctrl   = apb_req_i.paddr == `FCMP_REG_CTRL;
  assign sel_status = apb_req_i.paddr == `FCMP_REG_STATUS;
  assign sel_count  = apb_req_i.paddr == `FCMP_REG_COUNT;
  assign addr_hit   = sel_opa | sel_opb | sel_ctrl | sel_status | sel_count;

  // operand and ctrl writes bounce while a compare runs
  assign busy_err = wr & busy_i & (sel_opa | sel_opb | sel_ctrl);

  ////////////////////
  // registers
  ////////////////////

  fp32_u        opa_q;
  fp32_u        opb_q;
  fcmp_ctrl_t   ctrl_q;
  fcmp_result_t result_q;
  logic         start_q;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      opa_q    <= '0;
      opb_q    <= '0;
      ctrl_q   <= '0;
      result_q <= '0;
      start_q  <= 1'b0;
    end else begin
      if (wr && sel_opa && !busy_i) begin
        opa_q.raw <= apb_req_i.pwdata;
      end
      if (wr && sel_opb && !busy_i) begin
        opb_q.raw <= apb_req_i.pwdata;
      end
      if (wr && sel_ctrl && !busy_i) begin
        ctrl_q <= apb_req_i.pwdata[$bits(fcmp_ctrl_t)-1:0];
      end
      // one-cycle start after an accepted ctrl write
      start_q <= wr & sel_ctrl & ~busy_i;
      // comparator result held for status
      if (capture_i) begin
        result_q <= result_i;
      end
    end
  end

  ////////////////////
  // read path
  ////////////////////

  fcmp_status_t status;
  logic [31:0]  rd_data;

  assign status.busy   = busy_i;
  assign status.done   = done_i;
  assign status.result = result_q;

  always_comb begin
    rd_data = '0;
    if (sel_opa) begin
      rd_data = opa_q.raw;
    end else if (sel_opb) begin
      rd_data = opb_q.raw;
    end else if (sel_ctrl) begin
      rd_data = {{(32 - $bits(fcmp_ctrl_t)){1'b0}}, ctrl_q};
    end else if (sel_status) begin
      rd_data = {{(32 - $bits(fcmp_status_t)){1'b0}}, status};
    end else if (sel_count) begin
      rd_data = count_i;
    end
  end

  // unmapped reads come back as zero
  assign apb_rsp_o.prdata  = rd ? rd_data : '0;
  assign apb_rsp_o.pready  = 1'b1;
  assign apb_rsp_o.pslverr = (access & ~addr_hit) | busy_err;

  // status read acks done, any count write clears counters
  assign done_clr_o  = rd & sel_status;
  assign count_clr_o = wr & sel_count;

  assign start_o = start_q;
  assign opa_o   = opa_q;
  assign opb_o   = opb_q;
  assign ctrl_o  = ctrl_q;

endmodule

// ==== verilog/fcmp_ctrl_fsm.sv ====
module fcmp_ctrl_fsm (
  input  logic clk,
  input  logic rst_n_i,
  input  logic start_i,
  input  logic done_clr_i,
  output logic busy_o,
  output logic capture_o,
  output logic done_o,
  output logic irq_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_EVAL,
    ST_CAPTURE
  } state_e;

  state_e state_q;
  state_e state_cur;
  state_e state_nxt;
  logic   done_q;

  // start cycle is the eval cycle
  // operands and ctrl are stable from here on
  always_comb begin
    state_cur = state_q;
    if (state_q == ST_IDLE && start_i) begin
      state_cur = ST_EVAL;
    end
  end

  always_comb begin
    case (state_cur)
      ST_EVAL:    state_nxt = ST_CAPTURE;
      ST_CAPTURE: state_nxt = ST_IDLE;
      default:    state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_nxt;
    end
  end

  ////////////////////
  // done and irq
  ////////////////////

  // set on capture wins over a status read in the same cycle
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      done_q <= 1'b0;
    end else if (capture_o) begin
      done_q <= 1'b1;
    end else if (done_clr_i) begin
      done_q <= 1'b0;
    end
  end

  assign busy_o    = state_cur != ST_IDLE;
  assign capture_o = state_cur == ST_CAPTURE;
  assign done_o    = done_q;
  // level interrupt
  assign irq_o     = done_q;

endmodule

// ==== verilog/fcmp_event_counter.sv ====
module fcmp_event_counter (
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  logic                      capture_i,
  input  logic                      inv_i,
  input  logic                      clr_i,
  output fcmp_apb_pkg::fcmp_count_t count_o
);

  import fcmp_apb_pkg::*;

  fcmp_count_t cnt_q;

  // saturate at all ones, clear wins over capture
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (clr_i) begin
      cnt_q <= '0;
    end else if (capture_i) begin
      // every completed compare
      if (!(&cnt_q.cmp_count)) begin
        cnt_q.cmp_count <= cnt_q.cmp_count + 1'b1;
      end
      // only invalid ones
      if (inv_i && !(&cnt_q.inv_count)) begin
        cnt_q.inv_count <= cnt_q.inv_count + 1'b1;
      end
    end
  end

  assign count_o = cnt_q;

endmodule

// ==== verilog/fcmp_fp_pkg.sv ====
package fcmp_fp_pkg;

  ////////////////////
  // binary32 word
  ////////////////////

  // ieee-754 single field split
  typedef struct packed {
    logic        sign;
    logic [7:0]  exp;
    logic [22:0] mant;
  } fp32_fields_t;

  // raw bits on the bus side, fields on the unpack side
  typedef union packed {
    logic [31:0]  raw;
    fp32_fields_t f;
  } fp32_u;

  ////////////////////
  // unpacked operand
  ////////////////////

  typedef struct packed {
    logic        sign;
    // biased exponent, zero extended
    logic [9:0]  exp10;
    // hidden bit + mantissa
    logic [23:0] fract24;
    logic        snan;
    logic        qnan;
    logic        inf;
    logic        zero;
  } fp_operand_t;

  // comparator outputs as latched into status
  typedef struct packed {
    logic cmp_flag;
    logic inv;
    logic inf;
    logic addsub_agtb;
    logic addsub_aeqb;
  } fcmp_result_t;

endpackage

// ==== verilog/fcmp_params.svh ====
`ifndef FCMP_PARAMS_SVH
`define FCMP_PARAMS_SVH

////////////////////
// compare opcodes
////////////////////

// generic compare opcode width
`define FCMP_OPC_W  3
`define FCMP_OPC_EQ 3'd0
`define FCMP_OPC_NE 3'd1
`define FCMP_OPC_GT 3'd2
`define FCMP_OPC_GE 3'd3
`define FCMP_OPC_LT 3'd4
`define FCMP_OPC_LE 3'd5

////////////////////
// register map
////////////////////

`define FCMP_ADDR_W     5
`define FCMP_REG_OPA    5'h00
`define FCMP_REG_OPB    5'h04
`define FCMP_REG_CTRL   5'h08
`define FCMP_REG_STATUS 5'h0C
`define FCMP_REG_COUNT  5'h10

// one event counter, two share the COUNT word
`define FCMP_CNT_W 16

`endif

// ==== verilog/fcmp_top.sv ====
module fcmp_top (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  fcmp_apb_pkg::apb_req_t apb_req_i,
  output fcmp_apb_pkg::apb_rsp_t apb_rsp_o,
  output logic                   irq_o
);

  import fcmp_fp_pkg::*;
  import fcmp_apb_pkg::*;

  // sequencer handshake
  logic start;
  logic busy;
  logic capture;
  logic done;
  logic done_clr;
  logic count_clr;

  // operand path
  fp32_u        opa;
  fp32_u        opb;
  fcmp_ctrl_t   ctrl;
  fp_operand_t  op_a;
  fp_operand_t  op_b;
  fcmp_result_t result;
  fcmp_count_t  count;

  ////////////////////
  // bus and control
  ////////////////////

  fcmp_apb_regs u_regs (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .apb_req_i   (apb_req_i),
    .apb_rsp_o   (apb_rsp_o),
    .busy_i      (busy),
    .done_i      (done),
    .capture_i   (capture),
    .result_i    (result),
    .count_i     (count),
    .start_o     (start),
    .done_clr_o  (done_clr),
    .count_clr_o (count_clr),
    .opa_o       (opa),
    .opb_o       (opb),
    .ctrl_o      (ctrl)
  );

  fcmp_ctrl_fsm u_fsm (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .start_i    (start),
    .done_clr_i (done_clr),
    .busy_o     (busy),
    .capture_o  (capture),
    .done_o     (done),
    .irq_o      (irq_o)
  );

  ////////////////////
  // datapath
  ////////////////////

  fcmp_unpack u_unpack_a (
    .word_i (opa),
    .op_o   (op_a)
  );

  fcmp_unpack u_unpack_b (
    .word_i (opb),
    .op_o   (op_b)
  );

  pfpu32_fcmp u_fcmp (
    .ctrl_i   (ctrl),
    .opa_i    (op_a),
    .opb_i    (op_b),
    .result_o (result)
  );

  // completed and invalid compare events
  fcmp_event_counter u_counter (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .capture_i (capture),
    .inv_i     (result.inv),
    .clr_i     (count_clr),
    .count_o   (count)
  );

endmodule

// ==== verilog/fcmp_unpack.sv ====
module fcmp_unpack (
  input  fcmp_fp_pkg::fp32_u       word_i,
  output fcmp_fp_pkg::fp_operand_t op_o
);

  // field summaries
  logic exp_max;
  logic exp_nz;
  logic mant_nz;

  assign exp_max = &word_i.f.exp;
  assign exp_nz  = |word_i.f.exp;
  assign mant_nz = |word_i.f.mant;

  ////////////////////
  // magnitude fields
  ////////////////////

  assign op_o.sign  = word_i.f.sign;
  assign op_o.exp10 = {2'b00, word_i.f.exp};

  // denormals keep hidden bit 0 and exponent 0
  // so plain integer order of the fields still holds
  assign op_o.fract24 = {exp_nz, word_i.f.mant};

  ////////////////////
  // class flags
  ////////////////////

  // quiet nan, top mantissa bit set
  assign op_o.qnan = exp_max & word_i.f.mant[22];

  // signalling nan, payload below the quiet bit
  assign op_o.snan = exp_max & ~word_i.f.mant[22] & mant_nz;

  // infinity
  assign op_o.inf = exp_max & ~mant_nz;

  // signed zero
  assign op_o.zero = ~exp_nz & ~mant_nz;

endmodule

// ==== verilog/pfpu32_fcmp.sv ====
`include "fcmp_params.svh"

// purely combinational, result latched by the register block
module pfpu32_fcmp (
  input  fcmp_apb_pkg::fcmp_ctrl_t   ctrl_i,
  input  fcmp_fp_pkg::fp_operand_t   opa_i,
  input  fcmp_fp_pkg::fp_operand_t   opb_i,
  output fcmp_fp_pkg::fcmp_result_t  result_o
);

  ////////////////////
  // exception logic
  ////////////////////

  logic qnan;
  logic snan;
  logic anan;
  logic eqne;

  assign qnan = opa_i.qnan | opb_i.qnan;
  assign snan = opa_i.snan | opb_i.snan;
  assign anan = qnan | snan;

  // eq or ne, ordered or not
  assign eqne = (ctrl_i.opcode == `FCMP_OPC_EQ) | (ctrl_i.opcode == `FCMP_OPC_NE);

  // invalid on snan for eq/ne
  // any nan in an ordered relational compare
  assign result_o.inv = (eqne & snan) | (~eqne & anan & ~ctrl_i.unordered);

  ////////////////////
  // magnitude compare
  ////////////////////

  logic exp_gt;
  logic exp_eq;
  logic fract_gt;
  logic fract_eq;
  logic all_zero;

  assign exp_gt   = opa_i.exp10 > opb_i.exp10;
  assign exp_eq   = opa_i.exp10 == opb_i.exp10;
  assign fract_gt = opa_i.fract24 > opb_i.fract24;
  assign fract_eq = opa_i.fract24 == opb_i.fract24;

  // +0 and -0 compare equal
  assign all_zero = opa_i.zero & opb_i.zero;

  // one-hot relation, all low when unordered
  logic a_lt_b;
  logic b_lt_a;
  logic a_eq_b;

  always_comb begin
    a_lt_b = 1'b0;
    b_lt_a = 1'b0;
    a_eq_b = 1'b0;
    if (anan) begin
      // unordered, no relation holds
      a_eq_b = 1'b0;
    end else if (opa_i.inf && opb_i.inf) begin
      // both infinite
      if (opa_i.sign == opb_i.sign) begin
        a_eq_b = 1'b1;
      end else begin
        a_lt_b = opa_i.sign;
        b_lt_a = opb_i.sign;
      end
    end else if (opa_i.inf) begin
      // a infinite, its sign decides
      a_lt_b = opa_i.sign;
      b_lt_a = ~opa_i.sign;
    end else if (opb_i.inf) begin
      a_lt_b = ~opb_i.sign;
      b_lt_a = opb_i.sign;
    end else if ((opa_i.sign != opb_i.sign) && !all_zero) begin
      // negative side is smaller
      a_lt_b = opa_i.sign;
      b_lt_a = opb_i.sign;
    end else if (all_zero) begin
      a_eq_b = 1'b1;
    end else if (!exp_eq) begin
      // same sign, larger exponent is larger for positives
      b_lt_a = exp_gt ^ opa_i.sign;
      a_lt_b = ~exp_gt ^ opa_i.sign;
    end else if (!fract_eq) begin
      // same sign and exponent
      b_lt_a = fract_gt ^ opa_i.sign;
      a_lt_b = ~fract_gt ^ opa_i.sign;
    end else begin
      a_eq_b = 1'b1;
    end
  end

  ////////////////////
  // flag generation
  ////////////////////

  logic ord_flag;

  // nan leaves every ordered relation false, ne included
  always_comb begin
    case (ctrl_i.opcode)
      `FCMP_OPC_EQ: ord_flag = a_eq_b;
      `FCMP_OPC_NE: ord_flag = ~a_eq_b & ~anan;
      `FCMP_OPC_GT: ord_flag = b_lt_a & ~a_eq_b;
      `FCMP_OPC_GE: ord_flag = b_lt_a | a_eq_b;
      `FCMP_OPC_LT: ord_flag = a_lt_b & ~a_eq_b;
      `FCMP_OPC_LE: ord_flag = a_lt_b | a_eq_b;
      default:      ord_flag = 1'b0;
    endcase
  end

  // unordered compare is true on any nan
  assign result_o.cmp_flag = (ctrl_i.unordered & anan) | ord_flag;
  assign result_o.inf      = opa_i.inf | opb_i.inf;

  // hints for add/sub operand swap, magnitude only
  assign result_o.addsub_agtb = exp_gt | (exp_eq & fract_gt);
  assign result_o.addsub_aeqb = exp_eq & fract_eq;

endmodule
